// ==== midi_pkg.sv ====
package midi_pkg;

    localparam int clocks_per_bit = 1600;            // 50 MHz over 31250 baud
    localparam int baud_w         = $clog2(clocks_per_bit); // baud counter width
    localparam int fifo_depth     = 8;               // byte FIFO entries
    localparam int fifo_addr_w    = 3;               // FIFO pointer width

    // high nibble of a status byte, bit 7 stripped
    typedef enum logic [2:0] {
        note_off,                                    // 8n
        note_on,                                     // 9n
        poly_at,                                     // An
        ctrl,                                        // Bn control change
        prog,                                        // Cn program change
        chan_at,                                     // Dn
        pitch,                                       // En pitch bend
        system                                       // Fx, no channel
    } msg_kind_t;

    typedef struct packed {
        logic       is_status;                       // bit 7 set
        msg_kind_t  kind;
        logic [3:0] channel;                         // or system sub-code
    } status_view_t;

    typedef struct packed {
        logic       is_status;                       // bit 7 clear
        logic [6:0] value;
    } data_view_t;

    // one MIDI byte seen either way
    typedef union packed {
        logic [7:0]   raw;
        status_view_t status;
        data_view_t   data;
    } midi_byte_u;

endpackage

// ==== synth_pkg.sv ====
package synth_pkg;

    localparam int voices  = 8;                      // voice count
    localparam int v_width = 3;                      // voice index bits

    typedef struct packed {
        logic       on;                              // 0 for note-off or vel 0
        logic [6:0] key;
        logic [6:0] velocity;
    } note_event_t;

    typedef struct packed {
        logic        ctrl_cmd;                       // control change pulse
        logic [6:0]  octrl;                          // controller number
        logic [6:0]  octrl_data;
        logic        prg_ch_cmd;                     // program change pulse
        logic [6:0]  prg_ch_data;
        logic        pitch_cmd;                      // pitch bend pulse
        logic [13:0] pitch_data;                     // msb:lsb
    } ctrl_event_t;

endpackage

// ==== midi_byte_source.sv ====
`timescale 1ns/100ps

module midi_byte_source (
    input  logic                 CLOCK_50,
    input  logic                 reset_reg_N,
    input  logic                 midi_rxd,
    input  logic                 uart_usb_sel,          // high selects cpu port
    input  logic [7:0]           socmidi_data_from_cpu,
    input  logic                 socmidi_write,
    output logic                 byte_strobe,
    output midi_pkg::midi_byte_u byte_data
);
    import midi_pkg::*;

    typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_t;

    rx_state_t         rx_state;
    logic [1:0]        rxd_sync;                     // two flop synchronizer
    logic [baud_w-1:0] baud_cnt;
    logic [2:0]        bit_cnt;                      // data bit index
    logic [7:0]        rx_shift;                     // lsb first
    logic              bit_tick;
    logic              half_tick;
    logic              rx_done;

    assign bit_tick  = baud_cnt == baud_w'(clocks_per_bit - 1);      // one bit later
    assign half_tick = baud_cnt == baud_w'(clocks_per_bit / 2 - 1);  // middle of start bit
    // stop bit sampled high
    assign rx_done   = !uart_usb_sel && rx_state == rx_stop && bit_tick && rxd_sync[1];

    always_ff @(posedge CLOCK_50) begin
        if (!reset_reg_N) begin
            rxd_sync <= 2'b11;                       // line idles high
            rx_state <= rx_idle;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            rxd_sync <= {rxd_sync[0], midi_rxd};
            baud_cnt <= baud_cnt + 1'b1;
            if (uart_usb_sel) begin
                rx_state <= rx_idle;                 // receiver parked
            end else begin
                case (rx_state)
                    rx_idle: begin
                        baud_cnt <= '0;
                        if (!rxd_sync[1])
                            rx_state <= rx_start;    // falling edge
                    end
                    rx_start: begin
                        if (half_tick) begin
                            baud_cnt <= '0;
                            bit_cnt  <= '0;
                            rx_state <= rxd_sync[1] ? rx_idle : rx_data; // glitch check
                        end
                    end
                    rx_data: begin
                        if (bit_tick) begin
                            baud_cnt <= '0;
                            bit_cnt  <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7)
                                rx_state <= rx_stop;
                        end
                    end
                    rx_stop: begin
                        if (bit_tick)
                            rx_state <= rx_idle;     // framing error just drops byte
                    end
                    default: rx_state <= rx_idle;
                endcase
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (rx_state == rx_data && bit_tick)
            rx_shift <= {rxd_sync[1], rx_shift[7:1]}; // shift in at bit middle
    end

    always_ff @(posedge CLOCK_50) begin
        if (!reset_reg_N)
            byte_strobe <= 1'b0;
        else
            byte_strobe <= uart_usb_sel ? socmidi_write : rx_done;
    end

    always_ff @(posedge CLOCK_50) begin
        byte_data.raw <= uart_usb_sel ? socmidi_data_from_cpu : rx_shift;
    end

endmodule

// ==== midi_byte_fifo.sv ====
`timescale 1ns/100ps

module midi_byte_fifo (
    input  logic                 CLOCK_50,
    input  logic                 reset_reg_N,
    input  logic                 push,
    input  midi_pkg::midi_byte_u push_data,
    input  logic                 pop,
    output midi_pkg::midi_byte_u head,           // show-ahead
    output logic                 not_empty,
    output logic                 overflow        // sticky
);
    import midi_pkg::*;

    midi_byte_u             mem [fifo_depth];
    logic [fifo_addr_w-1:0] wr_ptr;
    logic [fifo_addr_w-1:0] rd_ptr;
    logic [fifo_addr_w:0]   count;               // occupancy
    logic                   full;
    logic                   do_push;
    logic                   do_pop;

    assign full      = count == (fifo_addr_w + 1)'(fifo_depth);
    assign not_empty = count != '0;
    assign do_pop    = pop && not_empty;
    assign do_push   = push && (!full || do_pop); // pop frees a slot when full
    assign head      = mem[rd_ptr];

    always_ff @(posedge CLOCK_50) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge CLOCK_50) begin
        if (!reset_reg_N) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;         // wraps at depth
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;         // none or both
            endcase
            if (push && !do_push)
                overflow <= 1'b1;                // byte lost
        end
    end

endmodule

// ==== midi_event_parser.sv ====
`timescale 1ns/100ps

module midi_event_parser (
    input  logic                   CLOCK_50,
    input  logic                   reset_reg_N,
    input  logic [3:0]             midi_ch,
    input  midi_pkg::midi_byte_u   head,
    input  logic                   not_empty,
    output logic                   pop,
    output logic                   note_strobe,
    output synth_pkg::note_event_t note_event,
    output synth_pkg::ctrl_event_t ctrl_event
);
    import midi_pkg::*;

    msg_kind_t  run_kind;                        // running status
    logic [3:0] run_ch;
    logic       run_valid;
    logic       in_sysex;                        // skipping until EOX
    logic       have_first;                      // first data byte stored
    logic [6:0] first_byte;
    logic       event_cycle;                     // no pop in this cycle
    logic       is_rt;
    logic       is_chan;
    logic       take_data;
    logic       one_byte_msg;
    logic       msg_done;
    logic [6:0] data1;
    logic [6:0] data2;

    assign pop = not_empty && !event_cycle;      // decode then event cycle

    always_comb begin
        is_rt        = head.raw[7:3] == 5'b11111;               // F8..FF
        is_chan      = head.status.is_status && head.status.kind != system;
        take_data    = !head.data.is_status && run_valid && !in_sysex;
        one_byte_msg = run_kind == prog || run_kind == chan_at;
        msg_done     = pop && take_data && (have_first || one_byte_msg);
        data1        = have_first ? first_byte : head.data.value;
        data2        = head.data.value;
    end

    always_ff @(posedge CLOCK_50) begin
        if (!reset_reg_N) begin
            event_cycle           <= 1'b0;
            run_valid             <= 1'b0;
            in_sysex              <= 1'b0;
            have_first            <= 1'b0;
            note_strobe           <= 1'b0;
            ctrl_event.ctrl_cmd   <= 1'b0;
            ctrl_event.prg_ch_cmd <= 1'b0;
            ctrl_event.pitch_cmd  <= 1'b0;
        end else begin
            event_cycle           <= pop;
            note_strobe           <= 1'b0;       // all strobes one cycle
            ctrl_event.ctrl_cmd   <= 1'b0;
            ctrl_event.prg_ch_cmd <= 1'b0;
            ctrl_event.pitch_cmd  <= 1'b0;
            if (pop && head.status.is_status) begin
                if (is_chan) begin
                    run_kind   <= head.status.kind;
                    run_ch     <= head.status.channel;
                    run_valid  <= 1'b1;
                    in_sysex   <= 1'b0;
                    have_first <= 1'b0;
                end else if (!is_rt) begin
                    run_valid  <= 1'b0;          // system common
                    have_first <= 1'b0;
                    in_sysex   <= head.raw == 8'hf0; // F7 and others end it
                end
            end else if (pop && take_data) begin
                have_first <= !msg_done;
                first_byte <= head.data.value;
            end
            if (msg_done && run_ch == midi_ch) begin
                case (run_kind)
                    note_on, note_off: begin
                        note_strobe         <= 1'b1;
                        note_event.on       <= run_kind == note_on && data2 != 7'd0;
                        note_event.key      <= data1;
                        note_event.velocity <= data2;
                    end
                    ctrl: begin
                        ctrl_event.ctrl_cmd   <= 1'b1;
                        ctrl_event.octrl      <= data1;
                        ctrl_event.octrl_data <= data2;
                    end
                    prog: begin
                        ctrl_event.prg_ch_cmd  <= 1'b1;
                        ctrl_event.prg_ch_data <= data1; // single data byte
                    end
                    pitch: begin
                        ctrl_event.pitch_cmd  <= 1'b1;
                        ctrl_event.pitch_data <= {data2, data1}; // lsb came first
                    end
                    default: ;                   // aftertouch swallowed
                endcase
            end
        end
    end

endmodule

// ==== note_stack.sv ====
`timescale 1ns/100ps

module note_stack (
    input  logic                          CLOCK_50,
    input  logic                          reset_reg_N,
    input  logic [synth_pkg::voices-1:0]  voice_free,   // from synth engine
    input  logic                          note_strobe,
    input  synth_pkg::note_event_t        note_event,
    output logic                          note_on,
    output logic                          note_off,
    output logic [synth_pkg::v_width-1:0] cur_key_adr,
    output logic [6:0]                    cur_key_val,
    output logic [6:0]                    cur_vel,
    output logic [synth_pkg::voices-1:0]  keys_on,      // voice map
    output logic [synth_pkg::v_width:0]   active_keys
);
    import synth_pkg::*;

    logic [6:0]         key_reg [voices];        // key held per voice
    logic               hit;                     // key already sounding
    logic [v_width-1:0] hit_idx;
    logic               found_free;
    logic [v_width-1:0] free_idx;
    logic [v_width-1:0] voice_idx;
    logic               start_voice;
    logic               stop_voice;

    always_comb begin
        hit         = 1'b0;
        hit_idx     = '0;
        found_free  = 1'b0;
        free_idx    = '0;
        active_keys = '0;
        for (int i = voices - 1; i >= 0; i--) begin // downward so lowest wins
            if (keys_on[i] && key_reg[i] == note_event.key) begin
                hit     = 1'b1;
                hit_idx = v_width'(i);
            end
            if (voice_free[i] && !keys_on[i]) begin
                found_free = 1'b1;
                free_idx   = v_width'(i);
            end
            active_keys = active_keys + (v_width + 1)'(keys_on[i]);
        end
        voice_idx   = hit ? hit_idx : free_idx;  // retrigger before allocate
        start_voice = note_strobe && note_event.on && (hit || found_free);
        stop_voice  = note_strobe && !note_event.on && hit;
    end

    always_ff @(posedge CLOCK_50) begin
        if (!reset_reg_N) begin
            note_on  <= 1'b0;
            note_off <= 1'b0;
            keys_on  <= '0;
        end else begin
            note_on  <= start_voice;             // no voice left drops note
            note_off <= stop_voice;              // unheld key ignored
            if (start_voice)
                keys_on[voice_idx] <= 1'b1;
            else if (stop_voice)
                keys_on[voice_idx] <= 1'b0;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (start_voice)
            key_reg[voice_idx] <= note_event.key;
        if (start_voice || stop_voice) begin
            cur_key_adr <= voice_idx;            // held until next pulse
            cur_key_val <= note_event.key;
            cur_vel     <= note_event.velocity;
        end
    end

endmodule

// ==== synth_controller.sv ====
`timescale 1ns/100ps

module synth_controller (
    input  logic                          CLOCK_50,
    input  logic                          reset_reg_N,
    input  logic                          midi_rxd,       // 31250 baud serial in
    input  logic                          uart_usb_sel,
    input  logic [7:0]                    socmidi_data_from_cpu,
    input  logic                          socmidi_write,
    input  logic [3:0]                    midi_ch,        // own channel
    input  logic [synth_pkg::voices-1:0]  voice_free,
    output logic                          note_on,
    output logic                          note_off,
    output logic [synth_pkg::v_width-1:0] cur_key_adr,
    output logic [6:0]                    cur_key_val,
    output logic [6:0]                    cur_vel,
    output logic [synth_pkg::voices-1:0]  keys_on,
    output logic [synth_pkg::v_width:0]   active_keys,
    output synth_pkg::ctrl_event_t        ctrl_event,     // cc, program, pitch
    output logic                          overflow
);
    import midi_pkg::*;
    import synth_pkg::*;

    logic        byte_strobe;
    midi_byte_u  byte_data;
    midi_byte_u  fifo_head;
    logic        fifo_not_empty;
    logic        fifo_pop;
    logic        note_strobe;
    note_event_t note_event;

    midi_byte_source midi_byte_source_inst (
        .CLOCK_50              (CLOCK_50),
        .reset_reg_N           (reset_reg_N),
        .midi_rxd              (midi_rxd),
        .uart_usb_sel          (uart_usb_sel),
        .socmidi_data_from_cpu (socmidi_data_from_cpu),
        .socmidi_write         (socmidi_write),
        .byte_strobe           (byte_strobe),     // one per byte
        .byte_data             (byte_data)
    );

    midi_byte_fifo midi_byte_fifo_inst (
        .CLOCK_50    (CLOCK_50),
        .reset_reg_N (reset_reg_N),
        .push        (byte_strobe),
        .push_data   (byte_data),
        .pop         (fifo_pop),
        .head        (fifo_head),
        .not_empty   (fifo_not_empty),
        .overflow    (overflow)
    );

    midi_event_parser midi_event_parser_inst (
        .CLOCK_50    (CLOCK_50),
        .reset_reg_N (reset_reg_N),
        .midi_ch     (midi_ch),
        .head        (fifo_head),
        .not_empty   (fifo_not_empty),
        .pop         (fifo_pop),                  // at most every other cycle
        .note_strobe (note_strobe),
        .note_event  (note_event),
        .ctrl_event  (ctrl_event)
    );

    note_stack note_stack_inst (
        .CLOCK_50    (CLOCK_50),
        .reset_reg_N (reset_reg_N),
        .voice_free  (voice_free),
        .note_strobe (note_strobe),
        .note_event  (note_event),
        .note_on     (note_on),
        .note_off    (note_off),
        .cur_key_adr (cur_key_adr),
        .cur_key_val (cur_key_val),
        .cur_vel     (cur_vel),
        .keys_on     (keys_on),
        .active_keys (active_keys)
    );

endmodule

// ==== synth_controller_assertions.sv ====
`timescale 1ns/100ps

module synth_controller_assertions (
    input logic                          CLOCK_50,
    input logic                          reset_reg_N,
    input logic                          note_on,
    input logic                          note_off,
    input logic [synth_pkg::voices-1:0]  keys_on,
    input logic [synth_pkg::v_width:0]   active_keys,
    input synth_pkg::ctrl_event_t        ctrl_event
);
    logic any_cmd;

    assign any_cmd = ctrl_event.ctrl_cmd || ctrl_event.prg_ch_cmd || ctrl_event.pitch_cmd;

    on_off_exclusive: assert property (@(posedge CLOCK_50) disable iff (!reset_reg_N)
        !(note_on && note_off))
        else $error("note_on and note_off high in the same cycle");

    count_matches_map: assert property (@(posedge CLOCK_50) disable iff (!reset_reg_N)
        active_keys == $countones(keys_on))
        else $error("active_keys differs from the voice map");

    cmd_single_cycle: assert property (@(posedge CLOCK_50) disable iff (!reset_reg_N)
        any_cmd |=> !any_cmd)
        else $error("controller strobe longer than one cycle");

    // outputs clear one edge after reset is sampled low
    quiet_in_reset: assert property (@(posedge CLOCK_50)
        !reset_reg_N |=> !(note_on || note_off || any_cmd))
        else $error("strobe while reset held");

endmodule

bind synth_controller synth_controller_assertions synth_controller_assertions_inst (
    .CLOCK_50    (CLOCK_50),
    .reset_reg_N (reset_reg_N),
    .note_on     (note_on),
    .note_off    (note_off),
    .keys_on     (keys_on),
    .active_keys (active_keys),
    .ctrl_event  (ctrl_event)
);

// ==== tb_synth_controller.sv ====
`timescale 1ns/100ps

module tb_synth_controller;
    import midi_pkg::*;
    import synth_pkg::*;

    localparam logic [3:0] own_ch      = 4'd5;
    localparam logic [3:0] other_ch    = 4'd6;
    localparam int         total_msgs  = 400;    // upper bound of messages sent
    localparam int         serial_bytes = 6;
    localparam logic [2:0] ev_on = 3'd0, ev_off = 3'd1, ev_ctrl = 3'd2;
    localparam logic [2:0] ev_prog = 3'd3, ev_pitch = 3'd4;

    typedef struct packed {
        logic [2:0]  kind;
        logic [2:0]  adr;                            // voice index
        logic [6:0]  key;                            // or controller number
        logic [6:0]  vel;                            // or controller value
        logic [13:0] val;                            // program or bend
        logic [7:0]  map;                            // keys_on after the event
    } exp_event_t;

    logic CLOCK_50, reset_reg_N, midi_rxd, uart_usb_sel, socmidi_write;
    logic [7:0] socmidi_data_from_cpu;
    logic [3:0] midi_ch;
    logic [voices-1:0] voice_free, keys_on;
    logic note_on, note_off, overflow;
    logic [v_width-1:0] cur_key_adr;
    logic [6:0] cur_key_val, cur_vel;
    logic [v_width:0] active_keys;
    ctrl_event_t ctrl_event;

    exp_event_t exp_q[$];                            // expected pulses in order
    logic [6:0] model_keys[voices];
    logic [7:0] model_map;
    logic [7:0] run_status;                          // last status the DUT saw
    logic [31:0] lfsr = 32'h1e2e05d5;

    synth_controller synth_controller_inst (.*);

    initial begin
        CLOCK_50 = 1'b0;
        forever #50 CLOCK_50 = ~CLOCK_50;
    end

    initial begin
        #(64'(total_msgs * 20 + serial_bytes * 16000) * 100);
        $display("watchdog expired, the DUT stopped producing events");
        $display("ERRORS FOUND");
        $fatal(1, "timeout");
    end

    function automatic int unsigned rand_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1; // galois step
            v = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    task automatic fail_value(input string name, input int expv, input int act);
        $display("ERR %0t %s expected %0h actual %0h", $time, name, expv, act);
        $display("ERRORS FOUND");
        $fatal(1, "value mismatch");
    endtask

    task automatic fail_msg(input string what);
        $display("%0t %s", $time, what);
        $display("ERRORS FOUND");
        $fatal(1, "check failed");
    endtask

    // voice allocation as the note stack rules describe it
    task automatic model_note(input logic on, input logic [6:0] key, input logic [6:0] vel);
        int hit;
        int fr;
        int v;
        hit = -1;
        fr  = -1;
        for (int i = voices - 1; i >= 0; i--) begin
            if (model_map[i] && model_keys[i] == key) hit = i;
            if (voice_free[i] && !model_map[i]) fr = i;
        end
        v = hit >= 0 ? hit : fr;
        if (v < 0 || (!on && hit < 0))
            return;                                  // dropped or unheld
        model_map[v] = on;
        model_keys[v] = key;
        exp_q.push_back({on ? ev_on : ev_off, 3'(v), key, vel, 14'd0, model_map});
    endtask

    task automatic cpu_write(input logic [7:0] b);
        socmidi_data_from_cpu = b;
        socmidi_write = 1'b1;
        @(posedge CLOCK_50);
        #10 socmidi_write = 1'b0;
        repeat (1 + rand_bits(2)) begin          // random gap
            @(posedge CLOCK_50);
            #10;
        end
    endtask

    task automatic serial_write(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};                     // stop, data lsb first, start
        for (int i = 0; i < 10; i++) begin
            midi_rxd = frame[i];
            repeat (clocks_per_bit) @(posedge CLOCK_50);
            #10;
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        if (uart_usb_sel) cpu_write(b);
        else serial_write(b);
    endtask

    task automatic send_msg(input logic [7:0] status, input logic [6:0] d1,
                            input logic [6:0] d2, input logic allow_run);
        if (status[3:0] == own_ch) begin         // expected event queued ahead of the bytes
            case (status[6:4])
                3'd0: model_note(1'b0, d1, d2);
                3'd1: model_note(d2 != 7'd0, d1, d2);  // vel 0 means off
                3'd3: exp_q.push_back({ev_ctrl, 3'd0, d1, d2, 14'd0, model_map});
                3'd4: exp_q.push_back({ev_prog, 3'd0, 7'd0, 7'd0, 14'(d1), model_map});
                3'd6: exp_q.push_back({ev_pitch, 3'd0, 7'd0, 7'd0, {d2, d1}, model_map});
                default: ;
            endcase
        end
        if (!(allow_run && status == run_status))
            send_byte(status);
        run_status = status;
        send_byte({1'b0, d1});
        if (status[7:4] != 4'hc && status[7:4] != 4'hd)
            send_byte({1'b0, d2});
    endtask

    task automatic random_msg();
        logic [6:0] key;
        logic [6:0] d;
        key = 7'(60 + rand_bits(3));                 // few keys so retriggers occur
        d = 7'(rand_bits(7));
        case (rand_bits(3))
            0, 1, 2: send_msg({4'h9, own_ch}, key, d, rand_bits(1) != 0);
            3: send_msg({4'h8, own_ch}, key, d, rand_bits(1) != 0);
            4: send_msg({4'hb, own_ch}, 7'(rand_bits(7)), d, rand_bits(1) != 0);
            5: send_msg({4'hc, own_ch}, d, 7'd0, rand_bits(1) != 0);
            6: send_msg({4'he, own_ch}, key, d, rand_bits(1) != 0);
            default: send_msg({4'h9, other_ch}, key, d, rand_bits(1) != 0);
        endcase
    endtask

    task automatic release_all();
        for (int i = 0; i < voices; i++)
            if (model_map[i]) send_msg({4'h8, own_ch}, model_keys[i], 7'd0, 1'b1);
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0) @(posedge CLOCK_50);
        repeat (20) @(posedge CLOCK_50);             // room for stray pulses
        #10;
    endtask

    task automatic apply_reset();
        reset_reg_N = 1'b0;
        repeat (4) @(posedge CLOCK_50);
        #10 reset_reg_N = 1'b1;
        model_map = '0;
        run_status = 8'h00;
    endtask

    // compare every output pulse with the head of the expected queue
    always @(negedge CLOCK_50) begin
        exp_event_t e;
        logic [2:0] got;
        if (reset_reg_N && (note_on || note_off || ctrl_event.ctrl_cmd ||
                ctrl_event.prg_ch_cmd || ctrl_event.pitch_cmd)) begin
            got = note_on ? ev_on : note_off ? ev_off : ctrl_event.ctrl_cmd ? ev_ctrl :
                  ctrl_event.prg_ch_cmd ? ev_prog : ev_pitch;
            assert (exp_q.size() != 0) else fail_msg("output pulse with no message behind it");
            e = exp_q.pop_front();
            assert (got == e.kind) else fail_value("event kind", e.kind, got);
            if (got == ev_on || got == ev_off) begin
                assert (cur_key_adr == e.adr) else fail_value("cur_key_adr", e.adr, cur_key_adr);
                assert (cur_key_val == e.key) else fail_value("cur_key_val", e.key, cur_key_val);
                assert (cur_vel == e.vel) else fail_value("cur_vel", e.vel, cur_vel);
            end
            assert (keys_on == e.map) else fail_value("keys_on", e.map, keys_on);
            assert (active_keys == $countones(e.map))
                else fail_value("active_keys", $countones(e.map), active_keys);
            if (got == ev_ctrl) begin
                assert (ctrl_event.octrl == e.key) else fail_value("octrl", e.key, ctrl_event.octrl);
                assert (ctrl_event.octrl_data == e.vel)
                    else fail_value("octrl_data", e.vel, ctrl_event.octrl_data);
            end
            if (got == ev_prog)
                assert (ctrl_event.prg_ch_data == e.val[6:0])
                    else fail_value("prg_ch_data", e.val, ctrl_event.prg_ch_data);
            if (got == ev_pitch)
                assert (ctrl_event.pitch_data == e.val)
                    else fail_value("pitch_data", e.val, ctrl_event.pitch_data);
        end
    end

    initial begin
        midi_rxd = 1'b1;                             // serial line idles high
        uart_usb_sel = 1'b1;
        socmidi_write = 1'b0;
        socmidi_data_from_cpu = 8'h00;
        midi_ch = own_ch;
        voice_free = '1;
        apply_reset();
        for (int i = 0; i < 200; i++) random_msg();  // notes, cc, program, bend
        release_all();
        wait_idle();
        send_byte({4'h9, own_ch});                   // real time inside a message
        send_byte(8'h30);
        send_byte(8'hf8);
        model_note(1'b1, 7'h30, 7'h40);
        send_byte(8'h40);
        send_byte(8'h30);                            // running status after F8
        send_byte(8'hfe);
        model_note(1'b0, 7'h30, 7'h00);
        send_byte(8'h00);
        send_byte(8'hf0);                            // sysex swallowed
        for (int i = 0; i < 4; i++) send_byte(8'(rand_bits(7)));
        send_byte(8'hf7);
        send_byte(8'h30);                            // no running status now
        send_byte(8'h40);
        run_status = 8'h00;
        release_all();
        wait_idle();
        voice_free = 8'b1010_0110;                   // some voices busy
        for (int k = 0; k < 5; k++) send_msg({4'h9, own_ch}, 7'(70 + k), 7'd90, 1'b1);
        release_all();
        wait_idle();
        voice_free = '1;
        for (int k = 0; k < 9; k++) send_msg({4'h9, own_ch}, 7'(80 + k), 7'd50, 1'b1);
        release_all();
        wait_idle();
        for (int pass_idx = 0; pass_idx < 2; pass_idx++) begin
            uart_usb_sel = pass_idx == 0;            // cpu first, then serial
            send_msg({4'h9, own_ch}, 7'd64, 7'd100, 1'b0);
            send_msg({4'hb, own_ch}, 7'd7, 7'd99, 1'b0);
            wait_idle();
        end
        uart_usb_sel = 1'b1;
        release_all();
        wait_idle();
        assert (overflow == 1'b0) else fail_value("overflow", 0, overflow);
        apply_reset();
        socmidi_data_from_cpu = 8'h01;               // data with no status
        socmidi_write = 1'b1;
        repeat (24) @(posedge CLOCK_50);
        #10 socmidi_write = 1'b0;
        repeat (30) @(posedge CLOCK_50);
        #10;
        assert (overflow == 1'b1) else fail_value("overflow", 1, overflow);
        apply_reset();
        for (int i = 0; i < 10; i++) random_msg();
        release_all();
        wait_idle();
        assert (overflow == 1'b0) else fail_value("overflow", 0, overflow);
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== filelist.f ====
midi_pkg.sv
synth_pkg.sv
midi_byte_source.sv
midi_byte_fifo.sv
midi_event_parser.sv
note_stack.sv
synth_controller.sv
synth_controller_assertions.sv
tb_synth_controller.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the synth controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_synth_controller -f filelist.f -o sim_synth_controller
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_synth_controller
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0
